/* sim/resampler_vectors.txt */
# W <channel> <sample, hex>    write one input sample
# R <channel> <expected, hex>  request one output, the result of the previous computation
W 0 000400
W 0 000800
W 0 000c00
W 0 001000
W 0 001400
W 0 001800
W 0 001c00
W 0 002000
# right channel samples are large, its sums wrap at 24 bits
W 1 600000
W 1 610000
W 1 620000
W 1 630000
W 1 640000
W 1 650000
W 1 660000
W 1 670000
R 0 000000
R 1 000000
R 0 002600
R 1 f70000
W 0 002400
W 1 680000
R 0 003300
R 1 e28000
R 0 003000

/* resampler_stereo.f */
common/resampler_pkg.sv
source/sample_ringbuf.sv
source/coeff_bank.sv
source/pipelined_multiplier.sv
polyphase_channel/polyphase_channel.sv
source/channel_arbiter.sv
source/resampler_stereo.sv
sim/resampler_stereo_properties.sv
sim/resampler_stereo_tb.sv

/* Makefile */
# Verilator build and run of the stereo resampler testbench

VERILATOR ?= verilator
TOP       ?= resampler_stereo_tb
FILELIST  ?= resampler_stereo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/resampler_stereo_tb.sv */
`timescale 1ns/1ns

module resampler_stereo_tb;
    import resampler_pkg::*;

    localparam int FIRDEPTH      = 8;
    localparam int NUM_FIR       = 2;
    localparam int DECIM         = 1;
    localparam int MULT_LATENCY  = 4;
    localparam int RB_LEN        = 16;
    localparam int ACK_TIMEOUT   = 40;
    localparam int SETTLE_CYCLES = 20;

    logic                clk;
    logic                rst;
    logic [SAMPLE_W-1:0] in_data;
    logic [1:0]          in_valid;
    logic [1:0]          in_pop;
    logic [1:0]          out_req;
    logic [SAMPLE_W-1:0] out_data;
    logic [1:0]          out_ack;
    int                  pop_count [2];
    int                  req_count [2];

    resampler_stereo #(
        .FIRDEPTH(FIRDEPTH),
        .NUM_FIR(NUM_FIR),
        .DECIM(DECIM),
        .MULT_LATENCY(MULT_LATENCY),
        .RB_LEN(RB_LEN)
    ) resampler_stereo_inst (
        .clk(clk),
        .rst(rst),
        .in_data_i(in_data),
        .in_valid_i(in_valid),
        .in_pop_o(in_pop),
        .out_req_i(out_req),
        .out_data_o(out_data),
        .out_ack_o(out_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // count consumed input samples per channel
    always @(posedge clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (rst) begin
                pop_count[ch] <= 0;
            end else if (in_pop[ch]) begin
                pop_count[ch] <= pop_count[ch] + 1;
            end
        end
    end

    // inputs change and outputs are sampled 10 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic write_sample(input int ch, input logic [SAMPLE_W-1:0] value);
        in_data  = value;
        in_valid = 2'(1 << ch);
        next_cycle();
        in_data  = '0;
        in_valid = 2'b00;
    endtask

    task automatic request_output(input int ch, input logic [SAMPLE_W-1:0] expected);
        int waited;
        out_req[ch] = 1'b1;
        next_cycle();
        out_req = 2'b00;
        waited  = 0;
        while (!out_ack[ch]) begin
            if (waited == ACK_TIMEOUT) begin
                fail_run($sformatf("no ack from channel %0d within %0d cycles", ch, waited));
            end
            next_cycle();
            waited++;
        end
        check_value(32'(out_ack), 32'(1 << ch), "out_ack_o");
        check_value(32'(out_data), 32'(expected), $sformatf("channel %0d output", ch));
        req_count[ch]++;
        // let the computation finish before anything else happens
        for (int i = 0; i < SETTLE_CYCLES; i++) begin
            next_cycle();
            check_value(32'(out_ack), 32'd0, "out_ack_o while computing");
        end
        // one pop per NUM_FIR/DECIM requests, none from the other channel
        for (int c = 0; c < 2; c++) begin
            check_value(pop_count[c], req_count[c] * DECIM / NUM_FIR,
                        $sformatf("pop count of channel %0d", c));
        end
    endtask

    initial begin
        int             fd;
        int             code;
        int             ch;
        logic [31:0]    value;
        logic [63:0]    tok;
        logic [1023:0]  rest;

        rst          = 1'b1;
        in_data      = '0;
        in_valid     = 2'b00;
        out_req      = 2'b00;
        req_count[0] = 0;
        req_count[1] = 0;

        fd = $fopen("sim/resampler_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("could not open sim/resampler_vectors.txt");
        end

        for (int i = 0; i < 5; i++) begin
            next_cycle();
        end
        rst = 1'b0;

        // quiet outputs with no requests
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            check_value(32'(out_ack), 32'd0, "out_ack_o after reset");
            check_value(32'(in_pop), 32'd0, "in_pop_o after reset");
        end

        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "W" || tok == "R") begin
                code = $fscanf(fd, "%d %h", ch, value);
                if (code != 2 || ch < 0 || ch > 1) begin
                    fail_run("malformed line in the vectors file");
                end
                if (tok == "W") begin
                    write_sample(ch, value[SAMPLE_W-1:0]);
                end else begin
                    request_output(ch, value[SAMPLE_W-1:0]);
                end
            end else begin
                fail_run("unknown command in the vectors file");
            end
            code = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);

        if (req_count[0] == 0 || req_count[1] == 0) begin
            fail_run("the vectors file has no requests for one of the channels");
        end

        if (resampler_stereo_inst.props_inst.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("a bound assertion failed during the run");
        end
    end

endmodule

/* sim/resampler_stereo_properties.sv */
`timescale 1ns/1ns

module resampler_stereo_properties (
    input logic       clk,
    input logic       rst,
    input logic [1:0] out_req_i,
    input logic [1:0] out_ack_o,
    input logic [1:0] grant_i
);
    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // the two channels never answer in the same cycle
    ack_not_two_hot: assert property (@(posedge clk) disable iff (rst) !(&out_ack_o))
        else begin
            fail_count++;
            $error("both channels acked in the same cycle");
        end

    // a request hands its channel a one-hot grant in the next cycle
    left_grant_one_hot: assert property (@(posedge clk) disable iff (rst)
        out_req_i[0] |=> (grant_i == 2'b01))
        else begin
            fail_count++;
            $error("left channel does not hold a one-hot grant after its request");
        end

    right_grant_one_hot: assert property (@(posedge clk) disable iff (rst)
        (out_req_i == 2'b10) |=> (grant_i == 2'b10))
        else begin
            fail_count++;
            $error("right channel does not hold a one-hot grant after its request");
        end

    // ack exactly one cycle after the request
    left_req_to_ack: assert property (@(posedge clk) disable iff (rst)
        out_req_i[0] |=> out_ack_o[0])
        else begin
            fail_count++;
            $error("left channel did not ack one cycle after its request");
        end

    right_req_to_ack: assert property (@(posedge clk) disable iff (rst)
        out_req_i[1] |=> out_ack_o[1])
        else begin
            fail_count++;
            $error("right channel did not ack one cycle after its request");
        end

endmodule

bind resampler_stereo resampler_stereo_properties props_inst (
    .clk(clk),
    .rst(rst),
    .out_req_i(out_req_i),
    .out_ack_o(out_ack_o),
    .grant_i(grant)
);

/* source/resampler_stereo.sv */
`timescale 1ns/1ns

module resampler_stereo #(
    parameter int FIRDEPTH     = 8,
    parameter int NUM_FIR      = 2,
    parameter int DECIM        = 1,
    parameter int MULT_LATENCY = 4,
    parameter int RB_LEN       = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [resampler_pkg::SAMPLE_W-1:0] in_data_i,
    input  logic [1:0]                         in_valid_i,
    output logic [1:0]                         in_pop_o,
    input  logic [1:0]                         out_req_i,
    output logic [resampler_pkg::SAMPLE_W-1:0] out_data_o,
    output logic [1:0]                         out_ack_o
);
    import resampler_pkg::*;

    localparam int BANK_W = $clog2(NUM_FIR) + $clog2(FIRDEPTH);
    localparam int TAP_W  = $clog2(FIRDEPTH);
    localparam int RB_AW  = $clog2(RB_LEN);

    logic [1:0]                 grant;
    logic [BANK_W-1:0]          bank_addr_ch [2];
    logic [BANK_W-1:0]          bank_addr;
    logic signed [COEFF_W-1:0]  bank_data;
    logic signed [SAMPLE_W-1:0] mpcand_ch [2];
    logic signed [COEFF_W-1:0]  mplier_ch [2];
    logic signed [SAMPLE_W-1:0] mpcand;
    logic signed [COEFF_W-1:0]  mplier;
    logic signed [SAMPLE_W-1:0] mprod;
    logic [TAP_W-1:0]           rb_offset_ch [2];
    logic [SAMPLE_W-1:0]        rb_data_ch [2];
    logic [SAMPLE_W-1:0]        out_data_ch [2];

    // idle or ungranted channels drive zeros, so OR merges the buses
    assign bank_addr  = bank_addr_ch[GRANT_LEFT] | bank_addr_ch[GRANT_RIGHT];
    assign mpcand     = mpcand_ch[GRANT_LEFT] | mpcand_ch[GRANT_RIGHT];
    assign mplier     = mplier_ch[GRANT_LEFT] | mplier_ch[GRANT_RIGHT];
    assign out_data_o = out_data_ch[GRANT_LEFT] | out_data_ch[GRANT_RIGHT];

    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        logic [RB_AW-1:0] rb_offset_ext;

        assign rb_offset_ext = RB_AW'(rb_offset_ch[ch]);

        sample_ringbuf #(
            .LEN(RB_LEN)
        ) ringbuf_inst (
            .clk(clk),
            .rst(rst),
            .wr_data_i(in_data_i),
            .wr_en_i(in_valid_i[ch]),
            .pop_i(in_pop_o[ch]),
            .offset_i(rb_offset_ext),
            .rd_data_o(rb_data_ch[ch])
        );

        polyphase_channel #(
            .FIRDEPTH(FIRDEPTH),
            .NUM_FIR(NUM_FIR),
            .DECIM(DECIM),
            .MULT_LATENCY(MULT_LATENCY)
        ) channel_inst (
            .clk(clk),
            .rst(rst),
            .grant_i(grant[ch]),
            .bank_addr_o(bank_addr_ch[ch]),
            .bank_data_i(bank_data),
            .mpcand_o(mpcand_ch[ch]),
            .mplier_o(mplier_ch[ch]),
            .mprod_i(mprod),
            .rb_pop_o(in_pop_o[ch]),
            .rb_offset_o(rb_offset_ch[ch]),
            .rb_data_i(rb_data_ch[ch]),
            .out_req_i(out_req_i[ch]),
            .out_data_o(out_data_ch[ch]),
            .out_ack_o(out_ack_o[ch])
        );
    end

    coeff_bank #(
        .FIRDEPTH(FIRDEPTH),
        .NUM_FIR(NUM_FIR)
    ) coeff_bank_inst (
        .addr_i(bank_addr),
        .coeff_o(bank_data)
    );

    pipelined_multiplier #(
        .MULT_LATENCY(MULT_LATENCY)
    ) mult_inst (
        .clk(clk),
        .rst(rst),
        .mpcand_i(mpcand),
        .mplier_i(mplier),
        .mprod_o(mprod)
    );

    channel_arbiter arbiter_inst (
        .clk(clk),
        .rst(rst),
        .out_req_i(out_req_i),
        .grant_o(grant)
    );

endmodule

/* source/channel_arbiter.sv */
`timescale 1ns/1ns

module channel_arbiter (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] out_req_i,
    output logic [1:0] grant_o
);
    import resampler_pkg::*;

    grant_e     owner_q;
    grant_e     owner_next;
    logic [1:0] grant_q;

    // latest requester takes the shared path, left wins a tie
    always_comb begin
        owner_next = owner_q;
        if (out_req_i[0]) begin
            owner_next = GRANT_LEFT;
        end else if (out_req_i[1]) begin
            owner_next = GRANT_RIGHT;
        end
    end

    // grant is inactive in reset, one-hot afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= GRANT_LEFT;
            grant_q <= 2'b00;
        end else begin
            owner_q <= owner_next;
            if (owner_next == GRANT_LEFT) begin
                grant_q <= 2'b01;
            end else begin
                grant_q <= 2'b10;
            end
        end
    end

    // lands in the requester's RESULT cycle
    assign grant_o = grant_q;

endmodule

/* polyphase_channel/polyphase_channel.sv */
`timescale 1ns/1ns

module polyphase_channel #(
    parameter int FIRDEPTH     = 8,
    parameter int NUM_FIR      = 2,
    parameter int DECIM        = 1,
    parameter int MULT_LATENCY = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        grant_i,
    output logic [$clog2(NUM_FIR)+$clog2(FIRDEPTH)-1:0] bank_addr_o,
    input  logic signed [resampler_pkg::COEFF_W-1:0]    bank_data_i,
    output logic signed [resampler_pkg::SAMPLE_W-1:0]   mpcand_o,
    output logic signed [resampler_pkg::COEFF_W-1:0]    mplier_o,
    input  logic signed [resampler_pkg::SAMPLE_W-1:0]   mprod_i,
    output logic                                        rb_pop_o,
    output logic [$clog2(FIRDEPTH)-1:0]                 rb_offset_o,
    input  logic [resampler_pkg::SAMPLE_W-1:0]          rb_data_i,
    input  logic                                        out_req_i,
    output logic [resampler_pkg::SAMPLE_W-1:0]          out_data_o,
    output logic                                        out_ack_o
);
    import resampler_pkg::*;

    // NUM_FIR and FIRDEPTH are expected to be at least 2
    localparam int PH_W  = $clog2(NUM_FIR);
    localparam int TAP_W = $clog2(FIRDEPTH);

    // operand register, multiplier stages, accumulate
    localparam int PIPE_DEPTH = MULT_LATENCY + 2;
    localparam int LAST_CNT   = FIRDEPTH + PIPE_DEPTH - 1;
    localparam int CNT_W      = $clog2(LAST_CNT + 1);

    chan_state_e                state_q;
    logic [CNT_W-1:0]           depth_cnt_q;
    logic [PH_W-1:0]            phase_q;
    logic [PH_W-1:0]            dec_cnt_q;
    logic [TAP_W-1:0]           tap;
    logic signed [SAMPLE_W-1:0] sample_q;
    logic signed [COEFF_W-1:0]  coeff_q;
    logic signed [SAMPLE_W-1:0] acc_q;
    logic                       pop_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= IDLE;
            depth_cnt_q <= '0;
            phase_q     <= '0;
            dec_cnt_q   <= '0;
            sample_q    <= '0;
            coeff_q     <= '0;
            acc_q       <= '0;
            pop_q       <= 1'b0;
        end else begin
            // operands and tap counter idle at zero
            pop_q       <= 1'b0;
            sample_q    <= '0;
            coeff_q     <= '0;
            depth_cnt_q <= '0;

            case (state_q)
                IDLE: begin
                    if (out_req_i) begin
                        state_q <= RESULT;
                    end
                end
                RESULT: begin
                    // previous sum leaves on the ack this cycle
                    acc_q   <= '0;
                    state_q <= grant_i ? CALC : CALC_PENDING;
                end
                CALC_PENDING: begin
                    if (grant_i) begin
                        state_q <= CALC;
                    end
                end
                CALC: begin
                    // fetch operands for the real taps only, zeros while draining
                    if (int'(depth_cnt_q) < FIRDEPTH) begin
                        sample_q <= rb_data_i;
                        coeff_q  <= bank_data_i;
                    end

                    // product of tap 0 arrives once the pipeline has filled
                    if (int'(depth_cnt_q) >= PIPE_DEPTH - 1) begin
                        acc_q <= acc_q + mprod_i;
                    end

                    if (int'(depth_cnt_q) == LAST_CNT) begin
                        state_q <= NEXT_PHASE;
                    end else begin
                        depth_cnt_q <= depth_cnt_q + 1'b1;
                    end
                end
                NEXT_PHASE: begin
                    if (int'(phase_q) == NUM_FIR - 1) begin
                        phase_q <= '0;
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end

                    // consume an input each time the counter wraps past NUM_FIR
                    if (int'(dec_cnt_q) >= NUM_FIR - DECIM) begin
                        dec_cnt_q <= PH_W'(int'(dec_cnt_q) + DECIM - NUM_FIR);
                        pop_q     <= 1'b1;
                    end else begin
                        dec_cnt_q <= PH_W'(int'(dec_cnt_q) + DECIM);
                    end

                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign tap         = TAP_W'(depth_cnt_q);
    assign rb_offset_o = tap;
    assign rb_pop_o    = pop_q;

    // shared buses are ORed at the top, so stay zero without the grant
    assign bank_addr_o = grant_i ? {phase_q, tap} : '0;
    assign mpcand_o    = grant_i ? sample_q : '0;
    assign mplier_o    = grant_i ? coeff_q : '0;

    assign out_ack_o  = (state_q == RESULT);
    assign out_data_o = out_ack_o ? acc_q : '0;

endmodule

/* source/pipelined_multiplier.sv */
`timescale 1ns/1ns

module pipelined_multiplier #(
    parameter int MULT_LATENCY = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic signed [resampler_pkg::SAMPLE_W-1:0] mpcand_i,
    input  logic signed [resampler_pkg::COEFF_W-1:0]  mplier_i,
    output logic signed [resampler_pkg::SAMPLE_W-1:0] mprod_o
);
    import resampler_pkg::*;

    localparam int FULL_W = SAMPLE_W + COEFF_W;

    logic signed [FULL_W-1:0]   full_prod;
    logic signed [SAMPLE_W-1:0] stage_q [MULT_LATENCY];

    // full precision product
    assign full_prod = mpcand_i * mplier_i;

    // scale in the first stage, then carry the 24-bit value down the chain
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MULT_LATENCY; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= SAMPLE_W'(full_prod >>> PROD_SHIFT);
            for (int i = 1; i < MULT_LATENCY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // valid MULT_LATENCY cycles after the operands
    assign mprod_o = stage_q[MULT_LATENCY-1];

endmodule

/* source/coeff_bank.sv */
`timescale 1ns/1ns

module coeff_bank #(
    parameter int FIRDEPTH = 8,
    parameter int NUM_FIR  = 2
) (
    input  logic [$clog2(NUM_FIR)+$clog2(FIRDEPTH)-1:0] addr_i,
    output logic signed [resampler_pkg::COEFF_W-1:0]    coeff_o
);
    import resampler_pkg::*;

    localparam int PH_W  = $clog2(NUM_FIR);
    localparam int TAP_W = $clog2(FIRDEPTH);
    localparam int DEPTH = NUM_FIR * FIRDEPTH;

    typedef logic signed [COEFF_W-1:0] coeff_table_t [DEPTH];

    // phase p, tap t holds (4096 >> p) * (t + 1)
    // note: phase 0 tap 7 is 32768 and wraps to -32768 in Q1.15
    function automatic coeff_table_t fill_table();
        coeff_table_t tbl;
        for (int p = 0; p < NUM_FIR; p++) begin
            for (int t = 0; t < FIRDEPTH; t++) begin
                tbl[p * FIRDEPTH + t] = COEFF_W'((4096 >> p) * (t + 1));
            end
        end
        return tbl;
    endfunction

    localparam coeff_table_t COEFFS = fill_table();

    logic [PH_W-1:0]  phase;
    logic [TAP_W-1:0] tap;

    // address is {phase, tap}
    assign phase = addr_i[TAP_W +: PH_W];
    assign tap   = addr_i[TAP_W-1:0];

    // table is laid out phase-major
    assign coeff_o = COEFFS[phase * FIRDEPTH + tap];

endmodule

/* source/sample_ringbuf.sv */
`timescale 1ns/1ns

module sample_ringbuf #(
    parameter int LEN = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [resampler_pkg::SAMPLE_W-1:0] wr_data_i,
    input  logic                               wr_en_i,
    input  logic                               pop_i,
    input  logic [$clog2(LEN)-1:0]             offset_i,
    output logic [resampler_pkg::SAMPLE_W-1:0] rd_data_o
);
    import resampler_pkg::*;

    // LEN must be a power of two, pointers wrap naturally
    localparam int AW = $clog2(LEN);

    logic [SAMPLE_W-1:0] mem [LEN];
    logic [AW-1:0]       head_q;
    logic [AW-1:0]       base_q;
    logic [AW-1:0]       rd_addr;

    // sample storage
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[head_q] <= wr_data_i;
        end
    end

    // head moves on write, base on pop
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            base_q <= '0;
        end else begin
            if (wr_en_i) begin
                head_q <= head_q + 1'b1;
            end
            if (pop_i) begin
                base_q <= base_q + 1'b1;
            end
        end
    end

    // offset 0 is the oldest retained sample
    assign rd_addr   = base_q + offset_i;
    assign rd_data_o = mem[rd_addr];

endmodule

/* common/resampler_pkg.sv */
package resampler_pkg;

    // sample, accumulator and output width
    localparam int SAMPLE_W = 24;

    // coefficients are Q1.15
    localparam int COEFF_W = 16;

    // scales the raw product back to sample range
    localparam int PROD_SHIFT = 15;

    // per-channel engine states
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        RESULT       = 3'd1,
        CALC_PENDING = 3'd2,
        CALC         = 3'd3,
        NEXT_PHASE   = 3'd4
    } chan_state_e;

    // owner of the shared multiplier and ROM
    typedef enum logic {
        GRANT_LEFT  = 1'b0,
        GRANT_RIGHT = 1'b1
    } grant_e;

endpackage
